// ==== logic/mipsPkg.sv ====
package mipsPkg;

  // --------------------
  // widths
  // --------------------
  localparam int DATA_W     = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // --------------------
  // opcodes
  // --------------------
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_ORI   = 6'h0D;
  localparam logic [5:0] OP_LUI   = 6'h0F;

  // funct field of the R-format
  localparam logic [5:0] FN_ADD  = 6'h20;
  localparam logic [5:0] FN_SUB  = 6'h22;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_SLT  = 6'h2A;
  localparam logic [5:0] FN_SLTU = 6'h2B;

  // --------------------
  // ALU controls
  // --------------------
  // bit 3 inverts b and feeds the carry-in
  // low bits pick and, or, sum, signed-less or unsigned-less
  localparam logic [3:0] ALU_AND  = 4'b0000;
  localparam logic [3:0] ALU_OR   = 4'b0001;
  localparam logic [3:0] ALU_ADD  = 4'b0010;
  localparam logic [3:0] ALU_SUB  = 4'b1010;
  localparam logic [3:0] ALU_SLT  = 4'b1011;
  localparam logic [3:0] ALU_SLTU = 4'b1111;

  // operand source for the decode stage
  localparam logic [1:0] FWD_REG = 2'd0;
  localparam logic [1:0] FWD_EX  = 2'd1;
  localparam logic [1:0] FWD_MEM = 2'd2;

  // --------------------
  // instruction word
  // --------------------
  // same 32 bits seen as R-format or I-format
  typedef union packed {
    struct packed {
      logic [5:0]            op;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [REG_ADDR_W-1:0] rd;
      logic [4:0]            shamt;
      logic [5:0]            funct;
    } rFmt;
    struct packed {
      logic [5:0]            op;
      logic [REG_ADDR_W-1:0] rs;
      logic [REG_ADDR_W-1:0] rt;
      logic [15:0]           imm;
    } iFmt;
  } instrWord;

endpackage

// ==== logic/bypassIf.sv ====
`timescale 1ns/1ps

interface bypassIf;

  // result sitting in the ex register
  logic                            exValid;
  logic [mipsPkg::REG_ADDR_W-1:0]  exDest;
  logic [mipsPkg::DATA_W-1:0]      exValue;

  // result sitting in the mem register, also the one written back
  logic                            memValid;
  logic [mipsPkg::REG_ADDR_W-1:0]  memDest;
  logic [mipsPkg::DATA_W-1:0]      memValue;

  modport producer (
    output exValid, exDest, exValue,
    output memValid, memDest, memValue
  );

  modport check (input exValid, exDest, memValid, memDest);

  modport write (input memValid, memDest, memValue);

  modport forward (input exValue, memValue);

endinterface

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [mipsPkg::REG_ADDR_W-1:0] rs,
  input  logic [mipsPkg::REG_ADDR_W-1:0] rt,
  bypassIf.write                         wb,
  output logic [mipsPkg::DATA_W-1:0]     rsData,
  output logic [mipsPkg::DATA_W-1:0]     rtData
);

  logic [mipsPkg::DATA_W-1:0] regs [mipsPkg::NUM_REGS];

  // write port fed from the mem stage
  // entry 0 is never written
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < mipsPkg::NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wb.memValid && (wb.memDest != '0))
    begin
      regs[wb.memDest] <= wb.memValue;
    end
  end

  // two combinational read ports, r0 reads as zero
  assign rsData = (rs == '0) ? '0 : regs[rs];
  assign rtData = (rt == '0) ? '0 : regs[rt];

endmodule

// ==== logic/hazardCheck.sv ====
`timescale 1ns/1ps

module hazardCheck (
  input  logic [mipsPkg::REG_ADDR_W-1:0] rs,
  input  logic [mipsPkg::REG_ADDR_W-1:0] rt,
  bypassIf.check                         byp,
  output logic [1:0]                     fwdA,
  output logic [1:0]                     fwdB
);

  // ex is the younger producer so it is tested first
  function automatic logic [1:0] pickSrc(
    input logic [mipsPkg::REG_ADDR_W-1:0] src,
    input logic                           exValid,
    input logic [mipsPkg::REG_ADDR_W-1:0] exDest,
    input logic                           memValid,
    input logic [mipsPkg::REG_ADDR_W-1:0] memDest
  );
    if (exValid && (exDest != '0) && (exDest == src))
    begin
      return mipsPkg::FWD_EX;
    end
    if (memValid && (memDest != '0) && (memDest == src))
    begin
      return mipsPkg::FWD_MEM;
    end
    return mipsPkg::FWD_REG;
  endfunction

  assign fwdA = pickSrc(rs, byp.exValid, byp.exDest, byp.memValid, byp.memDest);
  assign fwdB = pickSrc(rt, byp.exValid, byp.exDest, byp.memValid, byp.memDest);

endmodule

// ==== logic/operandDecode.sv ====
`timescale 1ns/1ps

module operandDecode (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           instrValid,
  input  logic [mipsPkg::DATA_W-1:0]     instr,
  input  logic [mipsPkg::DATA_W-1:0]     rsData,
  input  logic [mipsPkg::DATA_W-1:0]     rtData,
  input  logic [1:0]                     fwdA,
  input  logic [1:0]                     fwdB,
  bypassIf.forward                       byp,
  output logic [mipsPkg::REG_ADDR_W-1:0] rs,
  output logic [mipsPkg::REG_ADDR_W-1:0] rt,
  output logic                           opValid,
  output logic [mipsPkg::DATA_W-1:0]     srcA,
  output logic [mipsPkg::DATA_W-1:0]     srcB,
  output logic [3:0]                     aluCtrl,
  output logic [mipsPkg::REG_ADDR_W-1:0] dest
);

  logic                       dValid;
  mipsPkg::instrWord          dInstr;
  logic [mipsPkg::DATA_W-1:0] fwdValA;
  logic [mipsPkg::DATA_W-1:0] fwdValB;
  logic                       supported;

  function automatic logic [mipsPkg::DATA_W-1:0] pickOperand(
    input logic [1:0]                 sel,
    input logic [mipsPkg::DATA_W-1:0] regVal,
    input logic [mipsPkg::DATA_W-1:0] exVal,
    input logic [mipsPkg::DATA_W-1:0] memVal
  );
    case (sel)
      mipsPkg::FWD_EX:  return exVal;
      mipsPkg::FWD_MEM: return memVal;
      mipsPkg::FWD_REG: return regVal;
      default:          return regVal;
    endcase
  endfunction

  // --------------------
  // decode register
  // --------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      dValid <= 1'b0;
    else
      dValid <= instrValid;
  end

  always_ff @(posedge clk)
  begin
    dInstr <= instr;
  end

  assign rs = dInstr.rFmt.rs;
  assign rt = dInstr.rFmt.rt;

  // bypass muxes in front of the ALU
  assign fwdValA = pickOperand(fwdA, rsData, byp.exValue, byp.memValue);
  assign fwdValB = pickOperand(fwdB, rtData, byp.exValue, byp.memValue);

  // --------------------
  // decode
  // --------------------
  always_comb
  begin
    supported = 1'b0;
    aluCtrl   = mipsPkg::ALU_ADD;
    dest      = dInstr.rFmt.rd;
    srcA      = fwdValA;
    srcB      = fwdValB;
    case (dInstr.rFmt.op)
      mipsPkg::OP_RTYPE:
      begin
        supported = 1'b1;
        case (dInstr.rFmt.funct)
          mipsPkg::FN_ADD:  aluCtrl = mipsPkg::ALU_ADD;
          mipsPkg::FN_SUB:  aluCtrl = mipsPkg::ALU_SUB;
          mipsPkg::FN_AND:  aluCtrl = mipsPkg::ALU_AND;
          mipsPkg::FN_OR:   aluCtrl = mipsPkg::ALU_OR;
          mipsPkg::FN_SLT:  aluCtrl = mipsPkg::ALU_SLT;
          mipsPkg::FN_SLTU: aluCtrl = mipsPkg::ALU_SLTU;
          default:          supported = 1'b0;
        endcase
      end
      mipsPkg::OP_ADDI:
      begin
        supported = 1'b1;
        dest      = dInstr.iFmt.rt;
        srcB      = {{(mipsPkg::DATA_W-16){dInstr.iFmt.imm[15]}}, dInstr.iFmt.imm};
      end
      mipsPkg::OP_ORI:
      begin
        supported = 1'b1;
        aluCtrl   = mipsPkg::ALU_OR;
        dest      = dInstr.iFmt.rt;
        srcB      = {{(mipsPkg::DATA_W-16){1'b0}}, dInstr.iFmt.imm};
      end
      mipsPkg::OP_LUI:
      begin
        // upper immediate added to zero
        supported = 1'b1;
        dest      = dInstr.iFmt.rt;
        srcA      = '0;
        srcB      = {dInstr.iFmt.imm, {(mipsPkg::DATA_W-16){1'b0}}};
      end
      default:
        supported = 1'b0;
    endcase
  end

  // unknown opcodes and functs leave as a bubble
  assign opValid = dValid & supported;

endmodule

// ==== logic/execStage.sv ====
`timescale 1ns/1ps

module execStage (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           opValid,
  input  logic [mipsPkg::DATA_W-1:0]     srcA,
  input  logic [mipsPkg::DATA_W-1:0]     srcB,
  input  logic [3:0]                     aluCtrl,
  input  logic [mipsPkg::REG_ADDR_W-1:0] dest,
  bypassIf.producer                      byp,
  output logic                           resultValid,
  output logic [mipsPkg::REG_ADDR_W-1:0] resultDest,
  output logic [mipsPkg::DATA_W-1:0]     resultValue,
  output logic                           resultZero
);

  logic [mipsPkg::DATA_W-1:0]     bIn;
  logic [mipsPkg::DATA_W-1:0]     sum;
  logic                           nFlag;
  logic                           cFlag;
  logic                           vFlag;
  logic [mipsPkg::DATA_W-1:0]     aluResult;
  logic                           aluZero;

  logic                           exValid;
  logic [mipsPkg::REG_ADDR_W-1:0] exDest;
  logic [mipsPkg::DATA_W-1:0]     exValue;
  logic                           exZero;
  logic                           memValid;
  logic [mipsPkg::REG_ADDR_W-1:0] memDest;
  logic [mipsPkg::DATA_W-1:0]     memValue;
  logic                           memZero;

  // --------------------
  // ALU
  // --------------------
  // subtract as a + ~b + 1
  assign bIn = aluCtrl[3] ? ~srcB : srcB;

  // ripple-carry adder, one full adder per bit
  always_comb
  begin
    logic [mipsPkg::DATA_W:0] carry;
    carry[0] = aluCtrl[3];
    for (int i = 0; i < mipsPkg::DATA_W; i++)
    begin
      sum[i]     = srcA[i] ^ bIn[i] ^ carry[i];
      carry[i+1] = (srcA[i] & bIn[i]) | (srcA[i] & carry[i]) | (bIn[i] & carry[i]);
    end
    cFlag = carry[mipsPkg::DATA_W];
    // overflow when the carries into and out of the sign bit differ
    vFlag = carry[mipsPkg::DATA_W] ^ carry[mipsPkg::DATA_W-1];
  end

  assign nFlag = sum[mipsPkg::DATA_W-1];

  always_comb
  begin
    case (aluCtrl)
      mipsPkg::ALU_AND:  aluResult = srcA & srcB;
      mipsPkg::ALU_OR:   aluResult = srcA | srcB;
      mipsPkg::ALU_ADD:  aluResult = sum;
      mipsPkg::ALU_SUB:  aluResult = sum;
      // signed less is N != V
      mipsPkg::ALU_SLT:  aluResult = {{(mipsPkg::DATA_W-1){1'b0}}, nFlag ^ vFlag};
      // unsigned less means a borrow, so carry clear
      mipsPkg::ALU_SLTU: aluResult = {{(mipsPkg::DATA_W-1){1'b0}}, ~cFlag};
      default:           aluResult = '0;
    endcase
  end

  assign aluZero = (aluResult == '0);

  // --------------------
  // ex and mem registers
  // --------------------
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      exValid  <= 1'b0;
      memValid <= 1'b0;
    end
    else
    begin
      exValid  <= opValid;
      memValid <= exValid;
    end
  end

  always_ff @(posedge clk)
  begin
    exDest   <= dest;
    exValue  <= aluResult;
    exZero   <= aluZero;
    memDest  <= exDest;
    memValue <= exValue;
    memZero  <= exZero;
  end

  // both stages feed the bypass network
  assign byp.exValid  = exValid;
  assign byp.exDest   = exDest;
  assign byp.exValue  = exValue;
  assign byp.memValid = memValid;
  assign byp.memDest  = memDest;
  assign byp.memValue = memValue;

  // mem register is the writeback port
  assign resultValid = memValid;
  assign resultDest  = memDest;
  assign resultValue = memValue;
  assign resultZero  = memZero;

endmodule

// ==== logic/aluPipe.sv ====
`timescale 1ns/1ps

module aluPipe (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           instrValid,
  input  logic [mipsPkg::DATA_W-1:0]     instr,
  output logic                           resultValid,
  output logic [mipsPkg::REG_ADDR_W-1:0] resultDest,
  output logic [mipsPkg::DATA_W-1:0]     resultValue,
  output logic                           resultZero
);

  logic [mipsPkg::REG_ADDR_W-1:0] rs;
  logic [mipsPkg::REG_ADDR_W-1:0] rt;
  logic [mipsPkg::DATA_W-1:0]     rsData;
  logic [mipsPkg::DATA_W-1:0]     rtData;
  logic [1:0]                     fwdA;
  logic [1:0]                     fwdB;
  logic                           opValid;
  logic [mipsPkg::DATA_W-1:0]     srcA;
  logic [mipsPkg::DATA_W-1:0]     srcB;
  logic [3:0]                     aluCtrl;
  logic [mipsPkg::REG_ADDR_W-1:0] dest;

  // ex and mem results going back to decode
  bypassIf byp ();

  regFile regFile_i (
    .clk    (clk),
    .reset  (reset),
    .rs     (rs),
    .rt     (rt),
    .wb     (byp.write),
    .rsData (rsData),
    .rtData (rtData)
  );

  hazardCheck hazardCheck_i (
    .rs   (rs),
    .rt   (rt),
    .byp  (byp.check),
    .fwdA (fwdA),
    .fwdB (fwdB)
  );

  operandDecode operandDecode_i (
    .clk        (clk),
    .reset      (reset),
    .instrValid (instrValid),
    .instr      (instr),
    .rsData     (rsData),
    .rtData     (rtData),
    .fwdA       (fwdA),
    .fwdB       (fwdB),
    .byp        (byp.forward),
    .rs         (rs),
    .rt         (rt),
    .opValid    (opValid),
    .srcA       (srcA),
    .srcB       (srcB),
    .aluCtrl    (aluCtrl),
    .dest       (dest)
  );

  execStage execStage_i (
    .clk         (clk),
    .reset       (reset),
    .opValid     (opValid),
    .srcA        (srcA),
    .srcB        (srcB),
    .aluCtrl     (aluCtrl),
    .dest        (dest),
    .byp         (byp.producer),
    .resultValid (resultValid),
    .resultDest  (resultDest),
    .resultValue (resultValue),
    .resultZero  (resultZero)
  );

endmodule

// ==== testbench/aluPipe_properties.sv ====
`timescale 1ns/1ps

module aluPipe_properties (
  input logic                       clk,
  input logic                       reset,
  input logic                       instrValid,
  input logic                       resultValid,
  input logic [mipsPkg::DATA_W-1:0] resultValue,
  input logic                       resultZero
);

  // number of property failures so far
  int failCount = 0;

  noResultInReset: assert property (@(posedge clk) reset |-> !resultValid)
  else
  begin
    failCount++;
    $error("resultValid high while reset is active");
  end

  validKnown: assert property (@(posedge clk) disable iff (reset) !$isunknown(resultValid))
  else
  begin
    failCount++;
    $error("resultValid is unknown");
  end

  // zero flag tracks the value it came with
  zeroMatches: assert property (@(posedge clk) disable iff (reset)
    resultValid |-> (resultZero == (resultValue == '0)))
  else
  begin
    failCount++;
    $error("resultZero does not match resultValue");
  end

  fixedLatency: assert property (@(posedge clk) disable iff (reset)
    resultValid |-> $past(instrValid, 3))
  else
  begin
    failCount++;
    $error("result without an instruction three cycles earlier");
  end

endmodule

bind aluPipe aluPipe_properties props (
  .clk         (clk),
  .reset       (reset),
  .instrValid  (instrValid),
  .resultValid (resultValid),
  .resultValue (resultValue),
  .resultZero  (resultZero)
);

// ==== testbench/aluPipeTb.sv ====
`timescale 1ns/1ps

module aluPipeTb;

  parameter int SEED = 13094;

  localparam int NUM_RANDOM = 300;

  logic                           clk = 1'b0;
  logic                           reset;
  logic                           instrValid;
  logic [mipsPkg::DATA_W-1:0]     instr;
  logic                           resultValid;
  logic [mipsPkg::REG_ADDR_W-1:0] resultDest;
  logic [mipsPkg::DATA_W-1:0]     resultValue;
  logic                           resultZero;

  // program slots
  // an idle slot has its valid bit low
  logic [mipsPkg::DATA_W-1:0]     progWord [$];
  bit                             progValid [$];
  string                          progLabel [$];

  // model registers and expected results in issue order
  logic [mipsPkg::DATA_W-1:0]     modelRegs [mipsPkg::NUM_REGS];
  int                             dueQ [$];
  logic [mipsPkg::REG_ADDR_W-1:0] destQ [$];
  logic [mipsPkg::DATA_W-1:0]     valueQ [$];
  logic                           zeroQ [$];
  string                          nameQ [$];

  int edgeCnt = 0;
  int cycleLimit = 1000000;

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    edgeCnt <= edgeCnt + 1;
  end

  aluPipe aluPipe_i (
    .clk         (clk),
    .reset       (reset),
    .instrValid  (instrValid),
    .instr       (instr),
    .resultValid (resultValid),
    .resultDest  (resultDest),
    .resultValue (resultValue),
    .resultZero  (resultZero)
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1, "simulation stopped");
  endtask

  // --------------------
  // encoding helpers
  // --------------------
  function automatic logic [mipsPkg::DATA_W-1:0] encR(
    input logic [5:0]                     funct,
    input logic [mipsPkg::REG_ADDR_W-1:0] rd,
    input logic [mipsPkg::REG_ADDR_W-1:0] rs,
    input logic [mipsPkg::REG_ADDR_W-1:0] rt
  );
    mipsPkg::instrWord w;
    w.rFmt.op    = mipsPkg::OP_RTYPE;
    w.rFmt.rs    = rs;
    w.rFmt.rt    = rt;
    w.rFmt.rd    = rd;
    w.rFmt.shamt = 5'd0;
    w.rFmt.funct = funct;
    return w;
  endfunction

  function automatic logic [mipsPkg::DATA_W-1:0] encI(
    input logic [5:0]                     op,
    input logic [mipsPkg::REG_ADDR_W-1:0] rt,
    input logic [mipsPkg::REG_ADDR_W-1:0] rs,
    input logic [15:0]                    imm
  );
    mipsPkg::instrWord w;
    w.iFmt.op  = op;
    w.iFmt.rs  = rs;
    w.iFmt.rt  = rt;
    w.iFmt.imm = imm;
    return w;
  endfunction

  // only r0..r7 so that dependencies are frequent
  function automatic logic [mipsPkg::REG_ADDR_W-1:0] randReg();
    return 5'($urandom_range(7, 0));
  endfunction

  function automatic logic [mipsPkg::DATA_W-1:0] randomInstr();
    int         pick;
    logic [5:0] fn;
    if ($urandom_range(99, 0) < 5)
    begin
      // xor and lw stand in for codes the pipe does not know
      if ($urandom_range(1, 0) == 0)
        return encR(6'h26, randReg(), randReg(), randReg());
      return encI(6'h23, randReg(), randReg(), 16'($urandom));
    end
    pick = $urandom_range(8, 0);
    case (pick)
      0:       fn = mipsPkg::FN_ADD;
      1:       fn = mipsPkg::FN_SUB;
      2:       fn = mipsPkg::FN_AND;
      3:       fn = mipsPkg::FN_OR;
      4:       fn = mipsPkg::FN_SLT;
      5:       fn = mipsPkg::FN_SLTU;
      6:       return encI(mipsPkg::OP_ADDI, randReg(), randReg(), 16'($urandom));
      7:       return encI(mipsPkg::OP_ORI, randReg(), randReg(), 16'($urandom));
      default: return encI(mipsPkg::OP_LUI, randReg(), randReg(), 16'($urandom));
    endcase
    return encR(fn, randReg(), randReg(), randReg());
  endfunction

  // --------------------
  // reference model
  // --------------------
  function automatic bit refExec(
    input  logic [mipsPkg::DATA_W-1:0]     word,
    output logic [mipsPkg::REG_ADDR_W-1:0] dst,
    output logic [mipsPkg::DATA_W-1:0]     val,
    output logic                           zero
  );
    mipsPkg::instrWord          w;
    logic [mipsPkg::DATA_W-1:0] a;
    logic [mipsPkg::DATA_W-1:0] b;
    logic [mipsPkg::DATA_W-1:0] sext;
    bit                         produced;
    w        = word;
    a        = modelRegs[w.rFmt.rs];
    b        = modelRegs[w.rFmt.rt];
    sext     = {{16{w.iFmt.imm[15]}}, w.iFmt.imm};
    produced = 1'b1;
    dst      = w.rFmt.rd;
    val      = '0;
    case (w.rFmt.op)
      mipsPkg::OP_RTYPE:
        case (w.rFmt.funct)
          mipsPkg::FN_ADD:  val = a + b;
          mipsPkg::FN_SUB:  val = a - b;
          mipsPkg::FN_AND:  val = a & b;
          mipsPkg::FN_OR:   val = a | b;
          mipsPkg::FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          mipsPkg::FN_SLTU: val = (a < b) ? 32'd1 : 32'd0;
          default:          produced = 1'b0;
        endcase
      mipsPkg::OP_ADDI:
      begin
        dst = w.iFmt.rt;
        val = a + sext;
      end
      mipsPkg::OP_ORI:
      begin
        dst = w.iFmt.rt;
        val = a | {16'h0000, w.iFmt.imm};
      end
      mipsPkg::OP_LUI:
      begin
        dst = w.iFmt.rt;
        val = {w.iFmt.imm, 16'h0000};
      end
      default:
        produced = 1'b0;
    endcase
    zero = (val == '0);
    // r0 stays zero in the model
    if (produced && (dst != '0))
      modelRegs[dst] = val;
    return produced;
  endfunction

  // --------------------
  // program
  // --------------------
  task automatic addSlot(input bit valid, input logic [31:0] word, input string label);
    progValid.push_back(valid);
    progWord.push_back(word);
    progLabel.push_back(label);
  endtask

  task automatic buildDirected();
    // empty cycles first so nothing may come out
    repeat (3) addSlot(1'b0, 32'h0, "idle");
    addSlot(1'b1, encR(mipsPkg::FN_ADD, 5'd1, 5'd0, 5'd0), "add zero");
    addSlot(1'b1, encI(mipsPkg::OP_LUI, 5'd2, 5'd0, 16'h8000), "lui");
    addSlot(1'b1, encI(mipsPkg::OP_ADDI, 5'd3, 5'd0, 16'hFFFF), "addi sext");
    addSlot(1'b1, encI(mipsPkg::OP_ADDI, 5'd5, 5'd0, 16'h0001), "addi one");
    // most negative minus one wraps to most positive
    addSlot(1'b1, encR(mipsPkg::FN_SUB, 5'd4, 5'd2, 5'd5), "sub wrap");
    // -1 against 1 splits signed and unsigned compare
    addSlot(1'b1, encR(mipsPkg::FN_SLT, 5'd6, 5'd3, 5'd5), "slt neg");
    addSlot(1'b1, encR(mipsPkg::FN_SLTU, 5'd7, 5'd3, 5'd5), "sltu neg");
    addSlot(1'b1, encI(mipsPkg::OP_ORI, 5'd6, 5'd0, 16'h8001), "ori zext");
    addSlot(1'b1, encI(mipsPkg::OP_ADDI, 5'd7, 5'd0, 16'h8000), "addi neg");
    // a write to r0 is reported but r0 still reads zero
    addSlot(1'b1, encR(mipsPkg::FN_ADD, 5'd0, 5'd3, 5'd3), "add to r0");
    addSlot(1'b1, encR(mipsPkg::FN_OR, 5'd1, 5'd0, 5'd0), "read r0 ex");
    addSlot(1'b1, encR(mipsPkg::FN_OR, 5'd2, 5'd0, 5'd3), "read r0 mem");
    // two producers of r1 in flight
    addSlot(1'b1, encI(mipsPkg::OP_ADDI, 5'd1, 5'd0, 16'd5), "addi r1 old");
    addSlot(1'b1, encI(mipsPkg::OP_ADDI, 5'd1, 5'd0, 16'd7), "addi r1 new");
    addSlot(1'b1, encR(mipsPkg::FN_ADD, 5'd2, 5'd1, 5'd1), "younger wins");
    addSlot(1'b1, encR(mipsPkg::FN_AND, 5'd3, 5'd3, 5'd7), "and");
  endtask

  task automatic buildRandom();
    int gap;
    for (int i = 0; i < NUM_RANDOM; i++)
    begin
      addSlot(1'b1, randomInstr(), "random");
      if ($urandom_range(7, 0) == 0)
      begin
        gap = $urandom_range(2, 1);
        repeat (gap) addSlot(1'b0, $urandom, "idle");
      end
    end
  endtask

  // --------------------
  // stimulus
  // --------------------
  initial
  begin : mainFlow
    logic [mipsPkg::REG_ADDR_W-1:0] dst;
    logic [mipsPkg::DATA_W-1:0]     val;
    logic                           zero;
    reset      = 1'b1;
    instrValid = 1'b0;
    instr      = '0;
    void'($urandom(SEED));
    for (int i = 0; i < mipsPkg::NUM_REGS; i++)
      modelRegs[i] = '0;
    buildDirected();
    buildRandom();
    cycleLimit = 2 * progWord.size() + 50;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < progWord.size(); i++)
    begin
      @(posedge clk);
      #1;
      instrValid = progValid[i];
      instr      = progWord[i];
      if (progValid[i])
      begin
        if (refExec(progWord[i], dst, val, zero))
        begin
          // sampled at the next edge and due three edges after that
          dueQ.push_back(edgeCnt + 4);
          destQ.push_back(dst);
          valueQ.push_back(val);
          zeroQ.push_back(zero);
          nameQ.push_back($sformatf("%s #%0d word %08h", progLabel[i], i, progWord[i]));
        end
      end
    end
    @(posedge clk);
    #1;
    instrValid = 1'b0;
    while (dueQ.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);
    if (aluPipe_i.props.failCount == 0)
    begin
      $display("All tests passed!");
      $finish;
    end
    else
    begin
      abortRun($sformatf("%0d bound assertion failures", aluPipe_i.props.failCount));
    end
  end

  // --------------------
  // compare
  // --------------------
  task automatic checkFront();
    string name;
    name = nameQ[0];
    assert (resultValid === 1'b1)
      else abortRun($sformatf("ERR %s: resultValid expected 1 actual %b", name, resultValid));
    assert (resultDest === destQ[0])
      else abortRun($sformatf("ERR %s: resultDest expected %0d actual %0d",
                              name, destQ[0], resultDest));
    assert (resultValue === valueQ[0])
      else abortRun($sformatf("ERR %s: resultValue expected %08h actual %08h",
                              name, valueQ[0], resultValue));
    assert (resultZero === zeroQ[0])
      else abortRun($sformatf("ERR %s: resultZero expected %b actual %b",
                              name, zeroQ[0], resultZero));
    void'(dueQ.pop_front());
    void'(destQ.pop_front());
    void'(valueQ.pop_front());
    void'(zeroQ.pop_front());
    void'(nameQ.pop_front());
  endtask

  // outputs are stable at the falling edge and are checked against the coming edge
  always @(negedge clk)
  begin : compare
    int dueNow;
    if (!reset)
    begin
      dueNow = edgeCnt + 1;
      if ((dueQ.size() > 0) && (dueQ[0] == dueNow))
      begin
        checkFront();
      end
      else
      begin
        assert (resultValid === 1'b0)
          else abortRun($sformatf(
            "ERR no result due: resultValid expected 0 actual %b (dest %0d value %08h)",
            resultValid, resultDest, resultValue));
      end
    end
  end

  always @(negedge clk)
  begin
    if (edgeCnt > cycleLimit)
      abortRun($sformatf("timeout: the run did not finish within %0d cycles", cycleLimit));
  end

endmodule

// ==== src.f ====
logic/mipsPkg.sv
logic/bypassIf.sv
logic/regFile.sv
logic/hazardCheck.sv
logic/operandDecode.sv
logic/execStage.sv
logic/aluPipe.sv
testbench/aluPipe_properties.sv
testbench/aluPipeTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= aluPipeTb
SEED      ?= 13094
BUILD_DIR ?= obj_dir
FILELIST  ?= src.f

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP SEED BUILD_DIR FILELIST"

test:
	$(VERILATOR) --binary --timing --assert -f $(FILELIST) --top-module $(TOP) \
		-GSEED=$(SEED) --Mdir $(BUILD_DIR) -o $(TOP)
	@out=$$(./$(BUILD_DIR)/$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qF 'All tests passed!'

clean:
	rm -rf $(BUILD_DIR)
